// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;

    // Major opcodes in use
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // Decode to execute
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  is_branch;
        logic                  branch_ne;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [XLEN-1:0]       imm;
    } decode_t;

    // Execute to result, also the commit record
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic [XLEN-1:0]       data;
    } result_t;

endpackage

// ==== rtl/cpu_fetch.sv ====
`timescale 1ns/10ps

module cpu_fetch #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     redirect,
    input  logic [cpu_pkg::XLEN-1:0] redirect_pc,
    output logic [cpu_pkg::XLEN-1:0] pc
);

    localparam logic [cpu_pkg::XLEN-1:0] PC_STEP = 4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            // Taken branch from execute
            pc <= redirect_pc;
        end else begin
            pc <= pc + PC_STEP;
        end
    end

    // Branch targets come from execute and must stay word aligned
    a_redirect_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect |-> (redirect_pc[1:0] == 2'b00)
    );

endmodule

// ==== rtl/cpu_decode.sv ====
`timescale 1ns/10ps

module cpu_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           flush,
    input  logic [cpu_pkg::XLEN-1:0]       fetch_pc,
    input  logic [cpu_pkg::INST_W-1:0]     fetch_inst,
    input  logic [cpu_pkg::XLEN-1:0]       rs1_data,
    input  logic [cpu_pkg::XLEN-1:0]       rs2_data,
    input  cpu_pkg::result_t               ex_fwd,
    input  cpu_pkg::result_t               rs_fwd,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr,
    output cpu_pkg::decode_t               dec
);

    logic                           id_valid;
    logic [cpu_pkg::XLEN-1:0]       id_pc;
    logic [cpu_pkg::INST_W-1:0]     id_inst;

    cpu_pkg::opcode_e               opcode;
    logic [cpu_pkg::REG_ADDR_W-1:0] rd;
    logic [2:0]                     funct3;
    logic [6:0]                     funct7;
    logic [cpu_pkg::XLEN-1:0]       imm_i;
    logic [cpu_pkg::XLEN-1:0]       imm_u;
    logic [cpu_pkg::XLEN-1:0]       imm_b;

    // Youngest match wins, execute is one instruction ahead of result
    function automatic logic [cpu_pkg::XLEN-1:0] fwd_sel(
        input logic [cpu_pkg::REG_ADDR_W-1:0] addr,
        input logic [cpu_pkg::XLEN-1:0]       file_data,
        input cpu_pkg::result_t               ex,
        input cpu_pkg::result_t               rs
    );
        if (ex.valid && ex.we && ex.rd == addr) begin
            return ex.data;
        end else if (rs.valid && rs.we && rs.rd == addr) begin
            return rs.data;
        end
        return file_data;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        id_pc   <= fetch_pc;
        id_inst <= fetch_inst;
    end

    // Field split
    assign opcode   = cpu_pkg::opcode_e'(id_inst[6:0]);
    assign rd       = id_inst[11:7];
    assign funct3   = id_inst[14:12];
    assign rs1_addr = id_inst[19:15];
    assign rs2_addr = id_inst[24:20];
    assign funct7   = id_inst[31:25];

    assign imm_i = {{52{id_inst[31]}}, id_inst[31:20]};
    assign imm_u = {{32{id_inst[31]}}, id_inst[31:12], 12'b0};
    assign imm_b = {{51{id_inst[31]}}, id_inst[31], id_inst[7], id_inst[30:25],
                    id_inst[11:8], 1'b0};

    always_comb begin
        dec        = '0;
        dec.valid  = id_valid;
        dec.pc     = id_pc;
        dec.rd     = rd;
        dec.alu_op = cpu_pkg::ALU_ADD;
        dec.op_a   = fwd_sel(rs1_addr, rs1_data, ex_fwd, rs_fwd);
        dec.op_b   = fwd_sel(rs2_addr, rs2_data, ex_fwd, rs_fwd);
        case (opcode)
            cpu_pkg::OPC_OP: begin
                dec.we = 1'b1;
                case (funct3)
                    3'b000: begin
                        if (funct7[5]) begin
                            dec.alu_op = cpu_pkg::ALU_SUB;
                        end else begin
                            dec.alu_op = cpu_pkg::ALU_ADD;
                        end
                    end
                    3'b001:  dec.alu_op = cpu_pkg::ALU_SLL;
                    3'b010:  dec.alu_op = cpu_pkg::ALU_SLT;
                    3'b100:  dec.alu_op = cpu_pkg::ALU_XOR;
                    3'b101:  dec.alu_op = cpu_pkg::ALU_SRL;
                    3'b110:  dec.alu_op = cpu_pkg::ALU_OR;
                    3'b111:  dec.alu_op = cpu_pkg::ALU_AND;
                    default: dec.alu_op = cpu_pkg::ALU_ADD;
                endcase
            end
            cpu_pkg::OPC_OP_IMM: begin
                dec.we      = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
                case (funct3)
                    3'b100:  dec.alu_op = cpu_pkg::ALU_XOR;
                    3'b110:  dec.alu_op = cpu_pkg::ALU_OR;
                    3'b111:  dec.alu_op = cpu_pkg::ALU_AND;
                    default: dec.alu_op = cpu_pkg::ALU_ADD;
                endcase
            end
            cpu_pkg::OPC_LUI: begin
                dec.we      = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = cpu_pkg::ALU_PASS_B;
            end
            cpu_pkg::OPC_BRANCH: begin
                // Branches retire with rd x0, no write
                dec.rd        = '0;
                dec.is_branch = 1'b1;
                dec.branch_ne = funct3[0];
                dec.imm       = imm_b;
            end
            default: begin
                dec.we = 1'b0;
            end
        endcase
        if (dec.rd == '0) begin
            dec.we = 1'b0;
        end
    end

    a_known_opcode: assert property (
        @(posedge clk) disable iff (!rst_n)
        id_valid |-> opcode inside {cpu_pkg::OPC_OP, cpu_pkg::OPC_OP_IMM,
                                    cpu_pkg::OPC_LUI, cpu_pkg::OPC_BRANCH}
    );

endmodule

// ==== rtl/cpu_execute.sv ====
`timescale 1ns/10ps

module cpu_execute (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_pkg::decode_t         dec,
    output cpu_pkg::result_t         res,
    output logic                     redirect,
    output logic [cpu_pkg::XLEN-1:0] redirect_pc
);

    cpu_pkg::decode_t         exe_q;
    logic [cpu_pkg::XLEN-1:0] alu_b;
    logic [5:0]               shamt;
    logic [cpu_pkg::XLEN-1:0] alu_out;
    logic                     op_eq;

    // Own redirect drops the younger word coming from decode
    always_ff @(posedge clk) begin
        exe_q <= dec;
        if (!rst_n || redirect) begin
            exe_q.valid <= 1'b0;
        end
    end

    assign alu_b = exe_q.use_imm ? exe_q.imm : exe_q.op_b;
    assign shamt = alu_b[5:0];

    always_comb begin
        case (exe_q.alu_op)
            cpu_pkg::ALU_ADD:    alu_out = exe_q.op_a + alu_b;
            cpu_pkg::ALU_SUB:    alu_out = exe_q.op_a - alu_b;
            cpu_pkg::ALU_AND:    alu_out = exe_q.op_a & alu_b;
            cpu_pkg::ALU_OR:     alu_out = exe_q.op_a | alu_b;
            cpu_pkg::ALU_XOR:    alu_out = exe_q.op_a ^ alu_b;
            cpu_pkg::ALU_SLL:    alu_out = exe_q.op_a << shamt;
            cpu_pkg::ALU_SRL:    alu_out = exe_q.op_a >> shamt;
            cpu_pkg::ALU_SLT: begin
                alu_out = {63'b0, $signed(exe_q.op_a) < $signed(alu_b)};
            end
            cpu_pkg::ALU_PASS_B: alu_out = alu_b;
            default:             alu_out = '0;
        endcase
    end

    // Branch resolve
    assign op_eq       = (exe_q.op_a == exe_q.op_b);
    assign redirect    = exe_q.valid && exe_q.is_branch && (op_eq ^ exe_q.branch_ne);
    assign redirect_pc = exe_q.pc + exe_q.imm;

    always_comb begin
        res.valid = exe_q.valid;
        res.pc    = exe_q.pc;
        res.rd    = exe_q.rd;
        res.we    = exe_q.we;
        res.data  = exe_q.is_branch ? '0 : alu_out;
    end

    // Decode drops its word in the cycle after a taken branch
    a_redirect_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect |=> !dec.valid
    );

endmodule

// ==== rtl/cpu_result.sv ====
`timescale 1ns/10ps

module cpu_result (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cpu_pkg::result_t               res,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [cpu_pkg::XLEN-1:0]       rs1_data,
    output logic [cpu_pkg::XLEN-1:0]       rs2_data,
    output cpu_pkg::result_t               fwd,
    output logic                           commit_valid,
    output cpu_pkg::result_t               commit
);

    cpu_pkg::result_t         res_q;
    logic [cpu_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        res_q <= res;
        if (!rst_n) begin
            res_q.valid <= 1'b0;
        end
    end

    // x0 has no storage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (res_q.valid && res_q.we) begin
            regs[res_q.rd] <= res_q.data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    assign fwd          = res_q;
    assign commit       = res_q;
    assign commit_valid = res_q.valid;

    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        (commit_valid && commit.we) |-> (commit.rd != '0)
    );

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core #(
    parameter logic [cpu_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [cpu_pkg::XLEN-1:0]   pc,
    input  logic [cpu_pkg::INST_W-1:0] inst,
    output logic                       commit_valid,
    output cpu_pkg::result_t           commit
);

    logic                           redirect;
    logic [cpu_pkg::XLEN-1:0]       redirect_pc;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [cpu_pkg::XLEN-1:0]       rs1_data;
    logic [cpu_pkg::XLEN-1:0]       rs2_data;
    cpu_pkg::decode_t               dec;
    cpu_pkg::result_t               ex_res;
    cpu_pkg::result_t               rs_fwd;

    cpu_fetch #(
        .RESET_PC (RESET_PC)
    ) i_cpu_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    // Instruction port feeds decode directly
    cpu_decode i_cpu_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (redirect),
        .fetch_pc   (pc),
        .fetch_inst (inst),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_fwd     (ex_res),
        .rs_fwd     (rs_fwd),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .dec        (dec)
    );

    cpu_execute i_cpu_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec         (dec),
        .res         (ex_res),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    cpu_result i_cpu_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .res          (ex_res),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .fwd          (rs_fwd),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

endmodule

// ==== testbench/tb_cpu_core.sv ====
`timescale 1ns/10ps

module tb_cpu_core;

    localparam logic [cpu_pkg::XLEN-1:0] RESET_PC = 64'h200;
    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 4;
    localparam int NUM_COMMITS     = 2000;
    localparam int WATCHDOG_CYCLES = NUM_COMMITS * 4 + RESET_CYCLES;

    typedef enum logic [3:0] {
        K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLL, K_SRL, K_SLT,
        K_ADDI, K_ANDI, K_ORI, K_XORI, K_LUI, K_BEQ, K_BNE
    } kind_e;

    // Generator fields kept beside each encoded word
    typedef struct packed {
        kind_e                          kind;
        logic [cpu_pkg::REG_ADDR_W-1:0] rd;
        logic [cpu_pkg::REG_ADDR_W-1:0] rs1;
        logic [cpu_pkg::REG_ADDR_W-1:0] rs2;
        logic [cpu_pkg::XLEN-1:0]       imm;
    } prog_info_t;

    logic                       clk;
    logic                       rst_n;
    logic [cpu_pkg::XLEN-1:0]   pc;
    logic [cpu_pkg::INST_W-1:0] inst;
    logic                       commit_valid;
    cpu_pkg::result_t           commit;

    logic [cpu_pkg::INST_W-1:0] prog_word [256];
    prog_info_t                 prog_info [256];
    logic [cpu_pkg::XLEN-1:0]   model_regs [32];
    logic [cpu_pkg::XLEN-1:0]   model_pc;
    logic [31:0]                rng;

    cpu_core #(
        .RESET_PC (RESET_PC)
    ) i_cpu_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .inst         (inst),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Reuse recent destinations to exercise both forwarding paths
    function automatic logic [4:0] pick_src(input logic [4:0] last1, input logic [4:0] last2);
        logic [31:0] r;
        r = next_rand();
        case (r[1:0])
            2'd0:    return last1;
            2'd1:    return last2;
            default: return r[8:4];
        endcase
    endfunction

    // RV64I encodings
    function automatic logic [31:0] encode(input prog_info_t p);
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [12:0] b;
        f7 = 7'b0;
        b  = p.imm[12:0];
        case (p.kind)
            K_SUB: begin
                f3 = 3'b000;
                f7 = 7'b0100000;
            end
            K_SLL, K_BNE:   f3 = 3'b001;
            K_SLT:          f3 = 3'b010;
            K_XOR, K_XORI:  f3 = 3'b100;
            K_SRL:          f3 = 3'b101;
            K_OR, K_ORI:    f3 = 3'b110;
            K_AND, K_ANDI:  f3 = 3'b111;
            default:        f3 = 3'b000;
        endcase
        case (p.kind)
            K_ADDI, K_ANDI, K_ORI, K_XORI: begin
                return {p.imm[11:0], p.rs1, f3, p.rd, 7'b0010011};
            end
            K_LUI: begin
                return {p.imm[31:12], p.rd, 7'b0110111};
            end
            K_BEQ, K_BNE: begin
                return {b[12], b[10:5], p.rs2, p.rs1, f3, b[4:1], b[11], 7'b1100011};
            end
            default: begin
                return {f7, p.rs2, p.rs1, f3, p.rd, 7'b0110011};
            end
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] r2;
        logic [7:0]  w8;
        logic [4:0]  last1;
        logic [4:0]  last2;
        prog_info_t  p;
        last1 = '0;
        last2 = '0;
        for (int i = 0; i < 256; i++) begin
            r      = next_rand();
            r2     = next_rand();
            p      = '0;
            p.rd   = r[12:8];
            p.rs1  = pick_src(last1, last2);
            p.rs2  = pick_src(last1, last2);
            if (r[3:0] < 4'd6) begin
                p.kind = kind_e'({1'b0, r[6:4]});
            end else if (r[3:0] < 4'd10) begin
                case (r[5:4])
                    2'd0:    p.kind = K_ADDI;
                    2'd1:    p.kind = K_ANDI;
                    2'd2:    p.kind = K_ORI;
                    default: p.kind = K_XORI;
                endcase
                p.imm = {{52{r2[31]}}, r2[31:20]};
            end else if (r[3:0] < 4'd12) begin
                p.kind = K_LUI;
                p.imm  = {{32{r2[31]}}, r2[31:12], 12'b0};
            end else begin
                // Nonzero word offset, anywhere in the 256-word program
                p.kind = r[4] ? K_BNE : K_BEQ;
                p.rd   = '0;
                w8     = (r2[7:0] == 8'd0) ? 8'd1 : r2[7:0];
                p.imm  = {{54{w8[7]}}, w8, 2'b00};
            end
            if (p.kind != K_BEQ && p.kind != K_BNE) begin
                last2 = last1;
                last1 = p.rd;
            end
            prog_info[i] = p;
            prog_word[i] = encode(p);
        end
    endtask

    // Executes one instruction in program order
    task automatic model_step(output cpu_pkg::result_t want, output logic taken,
                              output logic [cpu_pkg::XLEN-1:0] target);
        prog_info_t               p;
        logic [cpu_pkg::XLEN-1:0] a;
        logic [cpu_pkg::XLEN-1:0] b;
        logic [cpu_pkg::XLEN-1:0] val;
        logic                     is_br;
        p     = prog_info[model_pc[9:2]];
        a     = model_regs[p.rs1];
        b     = model_regs[p.rs2];
        val   = '0;
        taken = 1'b0;
        is_br = (p.kind == K_BEQ) || (p.kind == K_BNE);
        case (p.kind)
            K_ADD:   val = a + b;
            K_SUB:   val = a - b;
            K_AND:   val = a & b;
            K_OR:    val = a | b;
            K_XOR:   val = a ^ b;
            K_SLL:   val = a << b[5:0];
            K_SRL:   val = a >> b[5:0];
            K_SLT:   val = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            K_ADDI:  val = a + p.imm;
            K_ANDI:  val = a & p.imm;
            K_ORI:   val = a | p.imm;
            K_XORI:  val = a ^ p.imm;
            K_LUI:   val = p.imm;
            K_BEQ:   taken = (a == b);
            K_BNE:   taken = (a != b);
            default: val = '0;
        endcase
        target     = model_pc + p.imm;
        want.valid = 1'b1;
        want.pc    = model_pc;
        want.rd    = p.rd;
        want.we    = !is_br && (p.rd != 5'd0);
        want.data  = val;
        if (want.we) begin
            model_regs[p.rd] = val;
        end
        model_pc = taken ? target : model_pc + 64'd4;
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_valid(input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("error at %0d ns: commit_valid is %b, expected %b",
                                $time, got, want));
        end
    endtask

    task automatic check_pc(input logic [cpu_pkg::XLEN-1:0] got,
                            input logic [cpu_pkg::XLEN-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("error at %0d ns: pc is %h, expected %h", $time, got, want));
        end
    endtask

    task automatic check_result(input cpu_pkg::result_t got, input cpu_pkg::result_t want);
        if (got.valid !== want.valid) begin
            abort_run($sformatf("error at %0d ns: commit.valid is %b, expected %b",
                                $time, got.valid, want.valid));
        end
        if (got.pc !== want.pc) begin
            abort_run($sformatf("error at %0d ns: commit.pc is %h, expected %h",
                                $time, got.pc, want.pc));
        end
        if (got.rd !== want.rd) begin
            abort_run($sformatf("error at %0d ns: commit.rd is %0d, expected %0d",
                                $time, got.rd, want.rd));
        end
        if (got.we !== want.we) begin
            abort_run($sformatf("error at %0d ns: commit.we is %b, expected %b",
                                $time, got.we, want.we));
        end
        if (got.data !== want.data) begin
            abort_run($sformatf("error at %0d ns: commit.data is %h, expected %h",
                                $time, got.data, want.data));
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        abort_run("commits stopped arriving before the expected count was reached");
    end

    initial begin
        cpu_pkg::result_t         want;
        logic                     taken;
        logic [cpu_pkg::XLEN-1:0] target;
        int                       commits;
        int                       bubble;
        rng = 32'hc308;
        build_program();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = RESET_PC;
        commits  = 0;
        // First commit lands three cycles after the first fetch
        bubble   = 3;
        rst_n    = 1'b0;
        inst     = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_pc(pc, RESET_PC);
        while (commits < NUM_COMMITS) begin
            if (bubble > 0) begin
                check_valid(commit_valid, 1'b0);
                bubble--;
            end else begin
                check_valid(commit_valid, 1'b1);
                model_step(want, taken, target);
                check_result(commit, want);
                commits++;
                if (taken) begin
                    // Two younger instructions are dropped
                    check_pc(pc, target);
                    bubble = 2;
                end
            end
            inst = prog_word[pc[9:2]];
            @(negedge clk);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/cpu_pkg.sv
rtl/cpu_fetch.sv
rtl/cpu_decode.sv
rtl/cpu_execute.sv
rtl/cpu_result.sv
rtl/cpu_core.sv
testbench/tb_cpu_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert --timescale 1ns/10ps -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/10ps
TOP        ?= tb_cpu_core
FILELIST   ?= compile.f
PASS_MSG   := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
